//--- Makefile
# Verilator build and run of the core wrapper testbench

TOP := tb_core_shell

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- logic/core_clock_gate.sv
// Main clock gate of the core. The core clock runs while the core is busy
// or while a debug request or interrupt is waiting; otherwise it stops.

module core_clock_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic gated_clk_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake requests act without waiting for a clock edge
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////
  // Glitch-free gate
  ////////////////////////////////

  // Enable only changes while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en;
    end
  end

  assign gated_clk_o = clk_i & en_latch;

endmodule

//--- logic/core_shell_top.sv
// Wrapper around the core: main clock gate, register file on the gated
// clock, and the scrambling key store. The core connects through these ports.

module core_shell_top #(
  parameter bit RV32E    = 1'b0,
  parameter bit Scramble = 1'b1
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Sleep control
  input  logic                         core_busy_i,
  input  logic                         debug_req_i,
  input  logic                         irq_pending_i,
  input  logic                         irq_nm_i,
  output logic                         core_sleep_o,

  // Register file
  input  rf_pkg::reg_addr_t            rf_raddr_a_i,
  input  rf_pkg::reg_addr_t            rf_raddr_b_i,
  output rf_pkg::reg_data_t            rf_rdata_a_o,
  output rf_pkg::reg_data_t            rf_rdata_b_o,
  input  rf_pkg::reg_addr_t            rf_waddr_i,
  input  rf_pkg::reg_data_t            rf_wdata_i,
  input  logic                         rf_we_i,

  // Scrambling
  input  logic                         scramble_ack_i,
  input  scramble_pkg::scr_key_t       scramble_key_i,
  input  scramble_pkg::scr_nonce_t     scramble_nonce_i,
  input  logic                         icache_inval_i,
  output logic                         scramble_req_o,
  output scramble_pkg::scr_key_t       key_o,
  output scramble_pkg::scr_nonce_t     nonce_o,
  output scramble_pkg::scr_nonce_buf_t nonce_buf_o,
  output logic                         key_valid_o
);

  logic gated_clk;

  core_clock_gate u_clock_gate (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .gated_clk_o  (gated_clk),
    .core_sleep_o (core_sleep_o)
  );

  // Stops together with the core
  register_file_ff #(
    .RV32E(RV32E)
  ) u_register_file (
    .clk_i    (gated_clk),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i)
  );

  scramble_key_store #(
    .Scramble(Scramble)
  ) u_key_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scramble_ack_i  (scramble_ack_i),
    .scramble_key_i  (scramble_key_i),
    .scramble_nonce_i(scramble_nonce_i),
    .icache_inval_i  (icache_inval_i),
    .scramble_req_o  (scramble_req_o),
    .key_o           (key_o),
    .nonce_o         (nonce_o),
    .nonce_buf_o     (nonce_buf_o),
    .key_valid_o     (key_valid_o)
  );

endmodule

//--- logic/register_file_ff.sv
// Flip-flop register file with two read ports and one write port.
// Clocked by the gated core clock; x0 and unused indices read as zero.

module register_file_ff #(
  parameter bit RV32E = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  rf_pkg::reg_addr_t raddr_a_i,
  input  rf_pkg::reg_addr_t raddr_b_i,
  output rf_pkg::reg_data_t rdata_a_o,
  output rf_pkg::reg_data_t rdata_b_o,
  input  rf_pkg::reg_addr_t waddr_i,
  input  rf_pkg::reg_data_t wdata_i,
  input  logic              we_i
);

  import rf_pkg::*;

  localparam int unsigned NumRegs = RV32E ? NumRegsE : NumRegsFull;

  logic [NumRegsFull-1:0] we_dec;
  reg_data_t              rf_reg [NumRegsFull];

  // One-hot write enables, registers 1 and up only
  always_comb begin
    we_dec = '0;
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = we_i & (waddr_i == reg_addr_t'(i));
    end
  end

  ////////////////////////////////
  // Storage
  ////////////////////////////////

  for (genvar i = 0; i < NumRegsFull; i++) begin : gen_regs
    if (i == 0 || i >= NumRegs) begin : gen_zero
      // Hardwired x0, and slots beyond the RV32E set
      assign rf_reg[i] = '0;
    end else begin : gen_flop
      reg_data_t rf_q;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          rf_q <= '0;
        end else if (we_dec[i]) begin
          rf_q <= wdata_i;
        end
      end

      assign rf_reg[i] = rf_q;
    end
  end

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

//--- logic/rf_pkg.sv
// Register file widths and types shared by the wrapper and the testbench.
// Import into a module body, or use scoped names in a port list.

package rf_pkg;

  // Full register set and the reduced RV32E set
  localparam int unsigned NumRegsFull = 32;
  localparam int unsigned NumRegsE    = 16;

  localparam int unsigned RegAddrW = 5;
  localparam int unsigned RegDataW = 32;

  // Register index, wide enough for the full set
  typedef logic [RegAddrW-1:0] reg_addr_t;

  // One architectural register
  typedef logic [RegDataW-1:0] reg_data_t;

endpackage

//--- logic/scramble_key_store.sv
// Holds the key and nonces for the scrambled memories and forwards the
// cache-invalidate event as a scramble request. Disabled, all outputs are low.

module scramble_key_store #(
  parameter bit Scramble = 1'b1
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        scramble_ack_i,
  input  scramble_pkg::scr_key_t      scramble_key_i,
  input  scramble_pkg::scr_nonce_t    scramble_nonce_i,
  input  logic                        icache_inval_i,
  output logic                        scramble_req_o,
  output scramble_pkg::scr_key_t      key_o,
  output scramble_pkg::scr_nonce_t    nonce_o,
  output scramble_pkg::scr_nonce_buf_t nonce_buf_o,
  output logic                        key_valid_o
);

  import scramble_pkg::*;

  if (Scramble) begin : gen_scramble
    // New key material on acknowledge; old nonce kept above the new one
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        key_o       <= ScrKeyDefault;
        nonce_o     <= ScrNonceDefault;
        nonce_buf_o <= {ScrNonceDefault, ScrNonceDefault};
        key_valid_o <= 1'b1;
      end else if (scramble_ack_i) begin
        key_o       <= scramble_key_i;
        nonce_o     <= scramble_nonce_i;
        nonce_buf_o <= {nonce_o, scramble_nonce_i};
        key_valid_o <= scramble_ack_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        scramble_req_o <= 1'b0;
      end else begin
        scramble_req_o <= icache_inval_i;
      end
    end
  end else begin : gen_noscramble
    assign scramble_req_o = 1'b0;
    assign key_o          = '0;
    assign nonce_o        = '0;
    assign nonce_buf_o    = '0;
    assign key_valid_o    = 1'b0;
  end

endmodule

//--- logic/scramble_pkg.sv
// Key material for the scrambled instruction-cache memories.
// Widths, types and the values the key store takes out of reset.

package scramble_pkg;

  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef logic [ScrKeyW-1:0]     scr_key_t;
  typedef logic [ScrNonceW-1:0]   scr_nonce_t;

  // Previous nonce in the upper half, current nonce in the lower half
  typedef logic [2*ScrNonceW-1:0] scr_nonce_buf_t;

  ////////////////////////////////
  // Reset defaults
  ////////////////////////////////

  // Used until the first key exchange completes
  localparam scr_key_t ScrKeyDefault =
      128'h3d8c_51e2_a7f0_9b46_6e15_c2d9_04ab_7f38;

  localparam scr_nonce_t ScrNonceDefault = 64'hb6a9_1f47_02ce_d835;

endpackage

//--- tb.f
logic/rf_pkg.sv
logic/scramble_pkg.sv
logic/core_clock_gate.sv
logic/register_file_ff.sv
logic/scramble_key_store.sv
logic/core_shell_top.sv
testbench/core_shell_chk.sv
testbench/tb_core_shell.sv

//--- testbench/core_shell_chk.sv
// Port-level assertions for the core wrapper, bound into core_shell_top.
// Covers scramble request timing, key validity, sleep and x0 reads.

module core_shell_chk #(
  parameter bit Scramble = 1'b1
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              icache_inval_i,
  input logic              scramble_req_o,
  input logic              key_valid_o,
  input logic              core_sleep_o,
  input rf_pkg::reg_addr_t rf_raddr_a_i,
  input rf_pkg::reg_addr_t rf_raddr_b_i,
  input rf_pkg::reg_data_t rf_rdata_a_o,
  input rf_pkg::reg_data_t rf_rdata_b_o
);

  // Request is the invalidate delayed by one cycle
  req_follows_inval_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !Scramble || (scramble_req_o == $past(icache_inval_i)))
    else $error("scramble_req_o does not follow icache_inval_i");

  key_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_valid_o == Scramble)
    else $error("key_valid_o wrong out of reset");

  sleep_known_a: assert property (@(posedge clk_i) !$isunknown(core_sleep_o))
    else $error("core_sleep_o is unknown");

  ////////////////////////////////
  // Hardwired x0
  ////////////////////////////////

  x0_read_a_a: assert property (@(posedge clk_i)
    (rf_raddr_a_i == '0) |-> (rf_rdata_a_o == '0))
    else $error("x0 read on port a is not zero");

  x0_read_b_a: assert property (@(posedge clk_i)
    (rf_raddr_b_i == '0) |-> (rf_rdata_b_o == '0))
    else $error("x0 read on port b is not zero");

endmodule

bind core_shell_top core_shell_chk #(
  .Scramble(Scramble)
) u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .icache_inval_i(icache_inval_i),
  .scramble_req_o(scramble_req_o),
  .key_valid_o   (key_valid_o),
  .core_sleep_o  (core_sleep_o),
  .rf_raddr_a_i  (rf_raddr_a_i),
  .rf_raddr_b_i  (rf_raddr_b_i),
  .rf_rdata_a_o  (rf_rdata_a_o),
  .rf_rdata_b_o  (rf_rdata_b_o)
);

//--- testbench/tb_core_shell.sv
// Directed testbench for the core wrapper: sleep control, register file on
// the gated clock, and the scrambling key store. Top module is tb_core_shell.

module tb_core_shell;

  import rf_pkg::*;
  import scramble_pkg::*;

  localparam int NumRegs   = int'(NumRegsFull);
  localparam int WaitLimit = 20;

  logic           clk_i;
  logic           rst_ni;
  logic           core_busy_i;
  logic           debug_req_i;
  logic           irq_pending_i;
  logic           irq_nm_i;
  logic           core_sleep_o;
  reg_addr_t      rf_raddr_a_i;
  reg_addr_t      rf_raddr_b_i;
  reg_data_t      rf_rdata_a_o;
  reg_data_t      rf_rdata_b_o;
  reg_addr_t      rf_waddr_i;
  reg_data_t      rf_wdata_i;
  logic           rf_we_i;
  logic           scramble_ack_i;
  scr_key_t       scramble_key_i;
  scr_nonce_t     scramble_nonce_i;
  logic           icache_inval_i;
  logic           scramble_req_o;
  scr_key_t       key_o;
  scr_nonce_t     nonce_o;
  scr_nonce_buf_t nonce_buf_o;
  logic           key_valid_o;

  int          errors;
  int          timeouts;
  bit          aborted;
  logic [31:0] lfsr_state;
  reg_data_t   rf_model [NumRegs];

  core_shell_top uut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////
  // Stimulus source
  ////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  ////////////////////////////////
  // Compare tasks
  ////////////////////////////////

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_key(input string name, input scr_key_t got, input scr_key_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_nonce(input string name, input scr_nonce_t got, input scr_nonce_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_buf(input string name, input scr_nonce_buf_t got,
                           input scr_nonce_buf_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_edges(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("error: %s took 0x%0h clock edges, expected 0x%0h", what, got, exp);
    end
  endtask

  ////////////////////////////////
  // Waits and bus helpers
  ////////////////////////////////

  // Counts rising edges until sleep reaches the wanted level
  task automatic wait_sleep(input logic exp, output int edges);
    edges = 0;
    while (core_sleep_o !== exp && !aborted) begin
      if (edges == WaitLimit) begin
        timeouts++;
        aborted = 1'b1;
        $display("timeout: core_sleep_o did not reach %0b within %0d cycles", exp, WaitLimit);
      end else begin
        @(negedge clk_i);
        #1;
        edges++;
      end
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk_i);
    rf_waddr_i = addr;
    rf_wdata_i = data;
    rf_we_i    = 1'b1;
    @(negedge clk_i);
    rf_we_i    = 1'b0;
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////

  task automatic test_sleep();
    int edges;
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    @(negedge clk_i);
    core_busy_i = 1'b1;
    #1;
    // Busy goes through a flop first
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    wait_sleep(1'b0, edges);
    if (aborted) return;
    check_edges("sleep exit after busy", edges, 1);
    @(negedge clk_i);
    core_busy_i = 1'b0;
    #1;
    wait_sleep(1'b1, edges);
    if (aborted) return;
    check_edges("sleep entry after busy drop", edges, 1);
    @(negedge clk_i);
    debug_req_i = 1'b1;
    #1;
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    @(negedge clk_i);
    debug_req_i = 1'b0;
    #1;
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    // Each interrupt level wakes on its own
    @(negedge clk_i);
    irq_pending_i = 1'b1;
    #1;
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    @(negedge clk_i);
    irq_pending_i = 1'b0;
    irq_nm_i      = 1'b1;
    #1;
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    @(negedge clk_i);
    irq_nm_i = 1'b0;
    #1;
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
  endtask

  task automatic test_rf_write_read();
    int          edges;
    logic [127:0] bits;
    @(negedge clk_i);
    core_busy_i = 1'b1;
    #1;
    wait_sleep(1'b0, edges);
    if (aborted) return;
    for (int i = 1; i < NumRegs; i++) begin
      take_bits(32, bits);
      rf_model[i] = bits[31:0];
      write_reg(reg_addr_t'(i), bits[31:0]);
    end
    // Port b walks the other way
    for (int i = 1; i < NumRegs; i++) begin
      @(negedge clk_i);
      rf_raddr_a_i = reg_addr_t'(i);
      rf_raddr_b_i = reg_addr_t'(NumRegs - i);
      #1;
      check_data($sformatf("rf_rdata_a_o[x%0d]", i), rf_rdata_a_o, rf_model[i]);
      check_data($sformatf("rf_rdata_b_o[x%0d]", NumRegs - i), rf_rdata_b_o,
                 rf_model[NumRegs - i]);
    end
    write_reg('0, 32'hdead_beef);
    @(negedge clk_i);
    rf_raddr_a_i = '0;
    rf_raddr_b_i = '0;
    #1;
    check_data("rf_rdata_a_o[x0]", rf_rdata_a_o, '0);
    check_data("rf_rdata_b_o[x0]", rf_rdata_b_o, '0);
  endtask

  task automatic test_rf_asleep();
    int edges;
    @(negedge clk_i);
    core_busy_i = 1'b0;
    #1;
    wait_sleep(1'b1, edges);
    if (aborted) return;
    write_reg(reg_addr_t'(5), ~rf_model[5]);
    @(negedge clk_i);
    rf_raddr_a_i = reg_addr_t'(5);
    #1;
    check_data("rf_rdata_a_o[x5]", rf_rdata_a_o, rf_model[5]);
  endtask

  task automatic test_key_reset();
    check_key("key_o", key_o, ScrKeyDefault);
    check_nonce("nonce_o", nonce_o, ScrNonceDefault);
    check_buf("nonce_buf_o", nonce_buf_o, {ScrNonceDefault, ScrNonceDefault});
    check_bit("key_valid_o", key_valid_o, 1'b1);
  endtask

  task automatic test_key_capture();
    logic [127:0] bits;
    scr_key_t     key;
    scr_key_t     prev_key;
    scr_nonce_t   nonce;
    scr_nonce_t   prev_nonce;
    prev_key   = ScrKeyDefault;
    prev_nonce = ScrNonceDefault;
    repeat (2) begin
      take_bits(128, bits);
      key = bits;
      take_bits(64, bits);
      nonce = bits[63:0];
      @(negedge clk_i);
      scramble_ack_i   = 1'b1;
      scramble_key_i   = key;
      scramble_nonce_i = nonce;
      #1;
      check_key("key_o", key_o, prev_key);
      @(negedge clk_i);
      scramble_ack_i = 1'b0;
      #1;
      check_key("key_o", key_o, key);
      check_nonce("nonce_o", nonce_o, nonce);
      check_buf("nonce_buf_o", nonce_buf_o, {prev_nonce, nonce});
      check_bit("key_valid_o", key_valid_o, 1'b1);
      prev_key   = key;
      prev_nonce = nonce;
    end
  endtask

  task automatic test_scramble_req();
    @(negedge clk_i);
    icache_inval_i = 1'b1;
    #1;
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
    @(negedge clk_i);
    icache_inval_i = 1'b0;
    #1;
    check_bit("scramble_req_o", scramble_req_o, 1'b1);
    @(negedge clk_i);
    #1;
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    core_busy_i      = 1'b0;
    debug_req_i      = 1'b0;
    irq_pending_i    = 1'b0;
    irq_nm_i         = 1'b0;
    rf_raddr_a_i     = '0;
    rf_raddr_b_i     = '0;
    rf_waddr_i       = '0;
    rf_wdata_i       = '0;
    rf_we_i          = 1'b0;
    scramble_ack_i   = 1'b0;
    scramble_key_i   = '0;
    scramble_nonce_i = '0;
    icache_inval_i   = 1'b0;
    errors           = 0;
    timeouts         = 0;
    aborted          = 1'b0;
    lfsr_state       = 32'd69;
    for (int i = 0; i < NumRegs; i++) begin
      rf_model[i] = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    test_key_reset();
    test_sleep();
    if (!aborted) test_rf_write_read();
    if (!aborted) test_rf_asleep();
    if (!aborted) test_key_capture();
    if (!aborted) test_scramble_req();
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
